/* project.f */
+incdir+.
instrPkg.sv
predictPkg.sv
branchDecode.sv
branchSolve.sv
predictTable.sv
branchUnit.sv
branchUnitChecker.sv
branchUnitTb.sv

/* Makefile */
# Verilator build and run of the branch unit testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build folder"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module branchUnitTb -f project.f -o sim
	@out=$$(./obj_dir/sim 2>&1); echo "$$out"; \
		echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

/* branchUnitTb.sv */
// branch unit testbench
// directed tests checked against a reference of the history table and resolution rules
`include "branch_macros.svh"

module branchUnitTb
    import instrPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int Period       = 40;
    localparam int ResetCycles  = 8;
    localparam int CondIssues   = 36;
    localparam int JumpIssues   = 8;
    localparam int TrainCycles  = 10;
    localparam int StreamIssues = 24;
    localparam int LimitCycles  = ResetCycles + CondIssues + JumpIssues + TrainCycles
                                  + StreamIssues + 40;  // reset test, drain, slack
    localparam int Entries      = 1 << `BHT_INDEX_BITS;
    localparam int TagLsb       = `BHT_INDEX_BITS + 2;

    logic        clk;
    logic        rst;
    logic        instrValid;
    logic [31:0] pc;
    instrWord    instr;
    logic [31:0] opA;
    logic [31:0] opB;
    logic        resolveValid;
    logic        predictionFailed;
    logic [31:0] correctionVector;

    // reference table
    logic        refValid  [Entries];
    logic [31:0] refPc     [Entries];
    logic [1:0]  refKind   [Entries];
    logic [31:0] refTarget [Entries];
    logic [1:0]  refCount  [Entries];

    // training of the instruction now in execute
    logic        pendOn = 1'b0;
    logic [31:0] pendPc;
    logic [1:0]  pendKind;
    logic        pendTaken;
    logic [31:0] pendTarget;
    logic        pendHit;
    logic [1:0]  pendCount;

    int          dueQ  [$];
    logic [31:0] vecQ  [$];
    logic        failQ [$];
    string       nameQ [$];
    int          negCount = 0;
    logic        lastFail;
    logic [31:0] rngState = 32'hec9d_352a;

    branchUnit uut (
        .clk              (clk),
        .rst              (rst),
        .instrValid       (instrValid),
        .pc               (pc),
        .instr            (instr),
        .opA              (opA),
        .opB              (opB),
        .resolveValid     (resolveValid),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    task automatic stopOnFailure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            stopOnFailure($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // write lands at the edge ending the execute cycle
    task automatic applyTraining();
        int i;
        if (pendOn) begin
            i = int'(pendPc[TagLsb-1:2]);
            refValid[i]  = 1'b1;
            refPc[i]     = pendPc;
            refKind[i]   = pendKind;
            refTarget[i] = pendTarget;
            if (!pendHit) begin
                refCount[i] = pendTaken ? 2'd2 : 2'd1;  // weak start
            end else if (pendTaken) begin
                refCount[i] = (pendCount == 2'd3) ? 2'd3 : pendCount + 2'd1;
            end else begin
                refCount[i] = (pendCount == 2'd0) ? 2'd0 : pendCount - 2'd1;
            end
        end
        pendOn = 1'b0;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            instrValid <= 1'b0;
            applyTraining();
        end
    endtask

    // drive one word and queue its expected result
    task automatic issue(input string name, input logic [31:0] pcV, input logic [31:0] word,
                         input logic [31:0] a, input logic [31:0] b);
        logic [5:0]  op;
        logic [4:0]  rt;
        logic [5:0]  fn;
        logic [31:0] pc4;
        logic [31:0] pc8;
        logic [31:0] target;
        logic [31:0] predTarget;
        logic [1:0]  kind;
        logic [1:0]  cnt;
        logic        taken;
        logic        jump;
        logic        hit;
        int          idx;
        @(posedge clk);
        instrValid <= 1'b1;
        pc         <= pcV;
        instr      <= word;
        opA        <= a;
        opB        <= b;
        op     = word[31:26];
        rt     = word[20:16];
        fn     = word[5:0];
        pc4    = pcV + 32'd4;
        pc8    = pcV + 32'd8;
        kind   = `BIsImme;
        taken  = 1'b0;
        jump   = 1'b0;
        target = pc8;
        case (op)
            `OP_BEQ:  taken = (a == b);
            `OP_BNE:  taken = (a != b);
            `OP_BLEZ: taken = a[31] || (a == 32'd0);
            `OP_BGTZ: taken = !a[31] && (a != 32'd0);
            `OP_REGIMM: begin
                if (rt == `RT_BLTZ) begin
                    taken = a[31];
                end else if (rt == `RT_BGEZ) begin
                    taken = !a[31];
                end else begin
                    kind = `BIsNone;
                end
            end
            `OP_J, `OP_JAL: begin
                jump   = 1'b1;
                kind   = (op == `OP_JAL) ? `BIsCall : `BIsImme;
                target = {pc4[31:28], word[25:0], 2'b00};
            end
            `OP_SPECIAL: begin
                jump   = (fn == `FN_JR) || (fn == `FN_JALR);
                kind   = (fn == `FN_JALR) ? `BIsCall : (fn == `FN_JR) ? `BIsRetn : `BIsNone;
                target = jump ? a : pc8;
            end
            default: kind = `BIsNone;
        endcase
        if (taken) begin
            target = pc4 + {{14{word[15]}}, word[15:0], 2'b00};  // conditional taken
        end
        taken = taken || jump;
        idx = int'(pcV[TagLsb-1:2]);
        hit = refValid[idx] && (refPc[idx][31:TagLsb] == pcV[31:TagLsb]);
        cnt = hit ? refCount[idx] : 2'd0;
        predTarget = (hit && refKind[idx] != `BIsNone && cnt >= 2'd2) ? refTarget[idx] : pc8;
        applyTraining();  // previous instruction trains after this lookup
        if (kind != `BIsNone) begin
            pendOn     = 1'b1;
            pendPc     = pcV;
            pendKind   = kind;
            pendTaken  = taken;
            pendTarget = target;
            pendHit    = hit;
            pendCount  = cnt;
        end
        lastFail = (predTarget != target);
        dueQ.push_back(negCount + 3);  // sampled at the falling edge after edge E+1
        vecQ.push_back(target);
        failQ.push_back(lastFail);
        nameQ.push_back(name);
    endtask

    task automatic resetTest();
        idle(3);
        @(negedge clk);
        check("reset valid", 32'd0, 32'(resolveValid));
        check("reset fail", 32'd0, 32'(predictionFailed));
    endtask

    task automatic condTest();
        logic [5:0]  ops [6] = '{`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_REGIMM, `OP_REGIMM};
        logic [4:0]  rts [6] = '{5'd3, 5'd3, 5'd0, 5'd0, `RT_BLTZ, `RT_BGEZ};
        logic [31:0] aVals [5] = '{32'd0, 32'hffff_fff0, 32'd5, 32'd5, 32'd1};
        logic [31:0] bVals [5] = '{32'd0, 32'd1, 32'd5, 32'd6, 32'd0};
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        for (int n = 0; n < CondIssues; n++) begin
            r = nextRand();
            a = (n % 6 == 5) ? nextRand() : aVals[n % 6];  // last slot random
            b = (n % 6 == 5) ? nextRand() : bVals[n % 6];
            issue($sformatf("cond %0d", n), 32'h0010_0000 + 32'(n * 68),
                  {ops[n / 6], 5'd2, rts[n / 6], r[15:0]}, a, b);
        end
    endtask

    task automatic jumpTest();
        logic [31:0] r;
        logic [31:0] word;
        for (int n = 0; n < JumpIssues; n++) begin
            r = nextRand();
            case (n % 4)
                0: word = {`OP_J, r[25:0]};
                1: word = {`OP_JAL, r[25:0]};
                2: word = {`OP_SPECIAL, 5'd4, 5'd0, 5'd0, 5'd0, `FN_JR};
                default: word = {`OP_SPECIAL, 5'd4, 5'd0, 5'd31, 5'd0, `FN_JALR};
            endcase
            issue($sformatf("jump %0d", n), 32'h0020_0000 + 32'(n * 68), word,
                  {r[31:2], 2'b00}, 32'd0);
            check("jump cold", 32'd1, 32'(lastFail));  // cold table misses every jump
        end
    endtask

    task automatic trainTest();
        logic [31:0] p;
        logic [31:0] w;
        p = 32'h0040_1000;
        w = {`OP_BEQ, 5'd1, 5'd2, 16'h0010};
        issue("train first", p, w, 32'd7, 32'd7);
        idle(1);
        issue("train second", p, w, 32'd7, 32'd7);
        check("train hit", 32'd0, 32'(lastFail));
        idle(1);
        issue("train not taken 1", p, w, 32'd7, 32'd8);
        idle(1);
        issue("train not taken 2", p, w, 32'd7, 32'd8);
        idle(1);
        issue("train retaken", p, w, 32'd7, 32'd7);
        check("train weak", 32'd1, 32'(lastFail));  // count back at 1
        idle(1);
    endtask

    task automatic streamTest();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] word;
        for (int n = 0; n < StreamIssues; n++) begin
            r = nextRand();
            a = nextRand();
            b = r[8] ? a : nextRand();
            case (r[2:0])
                3'd0, 3'd1: word = {6'b001000, 5'd1, 5'd2, r[31:16]};  // addi
                3'd2: word = {`OP_BEQ, 5'd1, 5'd2, r[31:16]};
                3'd3: word = {`OP_BNE, 5'd1, 5'd2, r[31:16]};
                3'd4: word = {`OP_REGIMM, 5'd1, `RT_BLTZ, r[31:16]};
                3'd5: word = {`OP_BGTZ, 5'd1, 5'd0, r[31:16]};
                3'd6: word = {`OP_J, r[31:6]};
                default: word = {`OP_SPECIAL, 5'd1, 5'd0, 5'd0, 5'd0, `FN_JR};
            endcase
            issue($sformatf("stream %0d", n), 32'h0080_0000 + 32'(n * 4), word, a, b);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // results come out in issue order at fixed latency
    initial begin
        forever begin
            @(negedge clk);
            negCount++;
            if (!rst) begin
                if (dueQ.size() > 0 && dueQ[0] == negCount) begin
                    check({nameQ[0], " valid"}, 32'd1, 32'(resolveValid));
                    check({nameQ[0], " vector"}, vecQ[0], correctionVector);
                    check({nameQ[0], " failed"}, 32'(failQ[0]), 32'(predictionFailed));
                    void'(dueQ.pop_front());
                    void'(vecQ.pop_front());
                    void'(failQ.pop_front());
                    void'(nameQ.pop_front());
                end else if (resolveValid || predictionFailed) begin
                    stopOnFailure("a result came out with no instruction due in that cycle");
                end
            end
        end
    end

    initial begin
        #(LimitCycles * Period);
        stopOnFailure("watchdog expired before the tests finished");
    end

    initial begin
        rst        = 1'b1;
        instrValid = 1'b0;
        pc         = 32'd0;
        instr      = '0;
        opA        = 32'd0;
        opB        = 32'd0;
        foreach (refValid[i]) begin
            refValid[i] = 1'b0;  // table starts empty after reset
        end
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        resetTest();
        condTest();
        jumpTest();
        trainTest();
        streamTest();
        idle(4);  // drain the pipeline
        @(negedge clk);
        check("drain", 32'd0, dueQ.size());
        $display("All checks passed");
        $finish;
    end

endmodule

/* branchUnitChecker.sv */
// branch unit output assertions
// bound to the top level, watches latency, failure flag and reset state
module branchUnitChecker (
    input logic clk,
    input logic rst,
    input logic instrValid,
    input logic resolveValid,
    input logic predictionFailed
);
    timeunit 1ns;
    timeprecision 1ps;

    // one edge in decode, one in execute
    resultLatency: assert property (@(posedge clk) disable iff (rst)
        resolveValid == $past(instrValid, 2))
        else $error("resolveValid out of step with instrValid");

    failOnlyWhenValid: assert property (@(posedge clk) disable iff (rst)
        predictionFailed |-> resolveValid)
        else $error("predictionFailed without resolveValid");

    quietInReset: assert property (@(posedge clk)
        rst |=> !resolveValid && !predictionFailed)
        else $error("outputs active during reset");

endmodule

bind branchUnit branchUnitChecker checker0 (
    .clk              (clk),
    .rst              (rst),
    .instrValid       (instrValid),
    .resolveValid     (resolveValid),
    .predictionFailed (predictionFailed)
);

/* branchUnit.sv */
// branch resolution unit top
// table lookup feeds decode, decode feeds execute, execute trains the table
module branchUnit
    import instrPkg::*, predictPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  logic [31:0] pc,
    input  instrWord    instr,
    input  logic [31:0] opA,  // rs value
    input  logic [31:0] opB,  // rt value
    output logic        resolveValid,
    output logic        predictionFailed,
    output logic [31:0] correctionVector
);

    pResult      lookup;
    bResult      bRes;
    logic        exeValid;
    branchType   exeBranchType;
    logic        exeIsJumpCall;
    logic [31:0] exeOpA;
    logic [31:0] exeOpB;
    logic [31:0] exePc;
    logic [31:0] exeJumpAddr;
    logic [31:0] exeBranchAddr;
    logic [31:0] exePcAdd8;
    pResult      exePred;
    logic        exeJSuccess;
    logic        exePc8Success;

    predictTable table0 (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .lookup     (lookup),
        .instrValid (instrValid),
        .bRes       (bRes)
    );

    branchDecode decode0 (
        .clk           (clk),
        .rst           (rst),
        .instrValid    (instrValid),
        .pc            (pc),
        .instr         (instr),
        .opA           (opA),
        .opB           (opB),
        .pred          (lookup),
        .exeValid      (exeValid),
        .exeBranchType (exeBranchType),
        .exeIsJumpCall (exeIsJumpCall),
        .exeOpA        (exeOpA),
        .exeOpB        (exeOpB),
        .exePc         (exePc),
        .exeJumpAddr   (exeJumpAddr),
        .exeBranchAddr (exeBranchAddr),
        .exePcAdd8     (exePcAdd8),
        .exePred       (exePred),
        .exeJSuccess   (exeJSuccess),
        .exePc8Success (exePc8Success)
    );

    branchSolve solve0 (
        .clk              (clk),
        .rst              (rst),
        .exeValid         (exeValid),
        .exeBranchType    (exeBranchType),
        .exeIsJumpCall    (exeIsJumpCall),
        .exeOpA           (exeOpA),
        .exeOpB           (exeOpB),
        .exePc            (exePc),
        .exeJumpAddr      (exeJumpAddr),
        .exeBranchAddr    (exeBranchAddr),
        .exePcAdd8        (exePcAdd8),
        .exePred          (exePred),
        .exeJSuccess      (exeJSuccess),
        .exePc8Success    (exePc8Success),
        .bRes             (bRes),
        .resolveValid     (resolveValid),
        .predictionFailed (predictionFailed),
        .correctionVector (correctionVector)
    );

endmodule

/* predictTable.sv */
// branch history table
// direct-mapped, 2-bit counters, combinational lookup and training at execute end
`include "branch_macros.svh"

module predictTable
    import predictPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] pc,
    output pResult      lookup,
    input  logic        instrValid,
    input  bResult      bRes
);

    localparam int Entries = 1 << `BHT_INDEX_BITS;
    localparam int TagLsb  = `BHT_INDEX_BITS + 2;

    logic [Entries-1:0]  entryValid;
    logic [31:TagLsb]    entryTag    [Entries];
    logic [1:0]          entryKind   [Entries];
    logic [31:0]         entryTarget [Entries];
    logic [1:0]          entryCount  [Entries];

    logic [`BHT_INDEX_BITS-1:0] rdIdx;
    logic [`BHT_INDEX_BITS-1:0] wrIdx;
    logic                       rdHit;
    logic                       trainEn;
    logic [1:0]                 nextCount;

    assign rdIdx = pc[TagLsb-1:2];
    assign rdHit = entryValid[rdIdx] && (entryTag[rdIdx] == pc[31:TagLsb]);

    always_comb begin
        lookup.valid = instrValid;
        lookup.hit   = rdHit;
        lookup.count = rdHit ? entryCount[rdIdx] : 2'b00;
        if (rdHit && entryKind[rdIdx] != `BIsNone && entryCount[rdIdx] >= 2'd2) begin
            lookup.target = entryTarget[rdIdx];
        end else begin
            lookup.target = pc + 32'd8;  // fall through
        end
    end

    assign wrIdx   = bRes.pc[TagLsb-1:2];
    assign trainEn = bRes.valid && (bRes.kind != `BIsNone);

    // saturating step on hit, weak start on miss
    always_comb begin
        if (!bRes.hit) begin
            nextCount = bRes.isTaken ? 2'd2 : 2'd1;
        end else if (bRes.isTaken) begin
            nextCount = (bRes.count == 2'd3) ? 2'd3 : bRes.count + 2'd1;
        end else begin
            nextCount = (bRes.count == 2'd0) ? 2'd0 : bRes.count - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (trainEn) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (trainEn) begin
            entryTag[wrIdx]    <= bRes.pc[31:TagLsb];
            entryKind[wrIdx]   <= bRes.kind;
            entryTarget[wrIdx] <= bRes.target;
            entryCount[wrIdx]  <= nextCount;
        end
    end

endmodule

/* branchSolve.sv */
// branch execute stage
// resolves direction and target, flags a wrong prediction, feeds table training
`include "branch_macros.svh"

module branchSolve
    import instrPkg::*, predictPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        exeValid,
    input  branchType   exeBranchType,
    input  logic        exeIsJumpCall,
    input  logic [31:0] exeOpA,
    input  logic [31:0] exeOpB,
    input  logic [31:0] exePc,
    input  logic [31:0] exeJumpAddr,
    input  logic [31:0] exeBranchAddr,
    input  logic [31:0] exePcAdd8,
    input  pResult      exePred,
    input  logic        exeJSuccess,
    input  logic        exePc8Success,
    output bResult      bRes,
    output logic        resolveValid,
    output logic        predictionFailed,
    output logic [31:0] correctionVector
);

    logic        isTaken;
    logic [31:0] target;
    logic [1:0]  kind;
    logic        predSuccess;
    logic        isEqual;
    logic        isZero;
    logic        isNeg;

    assign isEqual = (exeOpA == exeOpB);
    assign isZero  = (exeOpA == 32'd0);
    assign isNeg   = exeOpA[31];

    // direction
    always_comb begin
        isTaken = 1'b0;
        if (exeBranchType.isBranch) begin
            unique case (exeBranchType.branchCode)
                `BRANCH_CODE_BEQ: isTaken = isEqual;
                `BRANCH_CODE_BNE: isTaken = !isEqual;
                `BRANCH_CODE_BGE: isTaken = !isNeg;
                `BRANCH_CODE_BGT: isTaken = !isNeg && !isZero;
                `BRANCH_CODE_BLE: isTaken = isNeg || isZero;
                `BRANCH_CODE_BLT: isTaken = isNeg;
                default:          isTaken = 1'b1;  // j, jr
            endcase
        end
    end

    // true target, kind and prediction check
    always_comb begin
        kind        = `BIsNone;
        target      = exePcAdd8;
        predSuccess = exePc8Success;
        if (exeBranchType.isBranch) begin
            unique case (exeBranchType.branchCode)
                `BRANCH_CODE_J: begin
                    kind        = exeIsJumpCall ? `BIsCall : `BIsImme;
                    target      = exeJumpAddr;
                    predSuccess = exeJSuccess;
                end
                `BRANCH_CODE_JR: begin
                    kind        = exeIsJumpCall ? `BIsCall : `BIsRetn;
                    target      = exeOpA;
                    predSuccess = (exePred.target == exeOpA);
                end
                default: begin
                    kind = `BIsImme;
                    if (isTaken) begin
                        target      = exeBranchAddr;
                        predSuccess = (exePred.target == exeBranchAddr);
                    end
                end
            endcase
        end
    end

    assign bRes.valid   = exeValid;
    assign bRes.kind    = kind;
    assign bRes.isTaken = isTaken;
    assign bRes.target  = target;
    assign bRes.pc      = exePc;
    assign bRes.count   = exePred.count;
    assign bRes.hit     = exePred.hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            resolveValid     <= 1'b0;
            predictionFailed <= 1'b0;
        end else begin
            resolveValid     <= exeValid;
            predictionFailed <= exeValid && exePred.valid && !predSuccess;
        end
    end

    always_ff @(posedge clk) begin
        correctionVector <= target;  // always the resolved next pc
    end

endmodule

/* branchDecode.sv */
// branch decode stage
// classifies the word, forms candidate targets and registers them for execute
`include "branch_macros.svh"

module branchDecode
    import instrPkg::*, predictPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  logic [31:0] pc,
    input  instrWord    instr,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  pResult      pred,
    output logic        exeValid,
    output branchType   exeBranchType,
    output logic        exeIsJumpCall,
    output logic [31:0] exeOpA,
    output logic [31:0] exeOpB,
    output logic [31:0] exePc,
    output logic [31:0] exeJumpAddr,
    output logic [31:0] exeBranchAddr,
    output logic [31:0] exePcAdd8,
    output pResult      exePred,
    output logic        exeJSuccess,
    output logic        exePc8Success
);

    branchType   decType;
    logic        decIsJumpCall;
    logic [5:0]  funct;
    logic [31:0] pcAdd4;
    logic [31:0] jumpAddr;
    logic [31:0] branchAddr;
    logic [31:0] pcAdd8;

    assign funct = instr.iType.imm16[5:0];  // SPECIAL function field

    always_comb begin
        decType = '0;
        decIsJumpCall = 1'b0;
        unique case (instr.iType.opcode)
            `OP_BEQ:  decType = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_BEQ};
            `OP_BNE:  decType = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_BNE};
            `OP_BLEZ: decType = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_BLE};
            `OP_BGTZ: decType = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_BGT};
            `OP_REGIMM: begin
                if (instr.iType.rt == `RT_BLTZ) begin
                    decType = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_BLT};
                end else if (instr.iType.rt == `RT_BGEZ) begin
                    decType = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_BGE};
                end
            end
            `OP_SPECIAL: begin
                if (funct == `FN_JR || funct == `FN_JALR) begin
                    decType = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_JR};
                    decIsJumpCall = (funct == `FN_JALR);
                end
            end
            `OP_J, `OP_JAL: begin
                decType = '{isBranch: 1'b1, branchCode: `BRANCH_CODE_J};
                decIsJumpCall = (instr.jType.opcode == `OP_JAL);
            end
            default: decType = '0;  // ordinary instruction
        endcase
    end

    assign pcAdd4     = pc + 32'd4;
    assign pcAdd8     = pc + 32'd8;
    assign jumpAddr   = {pcAdd4[31:28], instr.jType.index26, 2'b00};
    assign branchAddr = pcAdd4 + {{14{instr.iType.imm16[15]}}, instr.iType.imm16, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            exeValid <= 1'b0;
        end else begin
            exeValid <= instrValid;
        end
    end

    // operands, addresses and prediction for execute
    always_ff @(posedge clk) begin
        exeBranchType <= decType;
        exeIsJumpCall <= decIsJumpCall;
        exeOpA        <= opA;
        exeOpB        <= opB;
        exePc         <= pc;
        exeJumpAddr   <= jumpAddr;
        exeBranchAddr <= branchAddr;
        exePcAdd8     <= pcAdd8;
        exePred       <= pred;
        exeJSuccess   <= (pred.target == jumpAddr);  // cheap checks done early
        exePc8Success <= (pred.target == pcAdd8);
    end

endmodule

/* predictPkg.sv */
// prediction records
// what fetch predicted, and what execute sends back to train the table
package predictPkg;

    typedef struct packed {
        logic        valid;
        logic        hit;     // tag matched at lookup
        logic [1:0]  count;
        logic [31:0] target;  // predicted next pc
    } pResult;

    typedef struct packed {
        logic        valid;
        logic [1:0]  kind;    // BIs* target kind
        logic        isTaken;
        logic [31:0] target;
        logic [31:0] pc;
        logic [1:0]  count;   // count seen at lookup
        logic        hit;
    } bResult;

endpackage

/* instrPkg.sv */
// instruction encoding types
// one word seen as I-type or J-type, plus the decoded branch kind
package instrPkg;

    // I-type view with the SPECIAL function field in imm16[5:0]
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } iTypeWord;

    // J-type view
    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index26;
    } jTypeWord;

    typedef union packed {
        iTypeWord iType;
        jTypeWord jType;
    } instrWord;

    typedef struct packed {
        logic       isBranch;
        logic [2:0] branchCode;  // BRANCH_CODE_* value
    } branchType;

endpackage

/* branch_macros.svh */
// branch unit constants
// condition codes, target kinds, MIPS opcode fields and history table depth
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

`define BRANCH_CODE_BEQ 3'b000
`define BRANCH_CODE_BNE 3'b001
`define BRANCH_CODE_BGE 3'b010
`define BRANCH_CODE_BGT 3'b011
`define BRANCH_CODE_BLE 3'b100
`define BRANCH_CODE_BLT 3'b101
`define BRANCH_CODE_J   3'b110
`define BRANCH_CODE_JR  3'b111

`define BIsNone 2'b00  // not a branch
`define BIsImme 2'b01  // direct or conditional
`define BIsCall 2'b10  // jal, jalr
`define BIsRetn 2'b11  // plain jr

`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define FN_JR      6'b001000
`define FN_JALR    6'b001001
`define RT_BLTZ    5'b00000
`define RT_BGEZ    5'b00001

`define BHT_INDEX_BITS 4  // 16 entries

`endif
